// ==== cacheProc/cacheProcCtl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheProcCtl (
    input  logic             clk,
    input  logic             rstN,
    input  logic             prRd,
    input  logic             prWr,
    input  cachePkg::addrT   addr,
    input  cachePkg::dataT   wrData,
    output cachePkg::dataT   rdData,
    output logic             cpuStall,
    output logic             comBusReq,
    input  logic             comBusGnt,
    output cachePkg::busOutT busOut,
    input  logic             dataInBus,
    input  logic             sharedIn,
    input  logic             memWriteDone,
    input  logic             allInvalidationDone,
    input  cachePkg::dataT   fillData,
    output cachePkg::indexT  procIndex,
    input  cachePkg::setT    procSet,
    output cachePkg::lineWrT procWr
);
    import cachePkg::*;

    procStateT state;
    procStateT stateNext;
    // Round-robin victim pointer per set
    wayT       rrPtr [SETS];
    // Way being upgraded or filled, captured when leaving Idle
    wayT       tgtWay;

    logic      req;
    tagT       reqTag;
    wayMaskT   hitMask;
    wayMaskT   freeMask;
    logic      hit;
    wayT       hitWay;
    lineT      hitLine;
    wayT       missWay;
    lineT      tgtLine;
    logic      done;
    mesiT      fillState;

    assign req       = prRd || prWr;
    assign reqTag    = addrTag(addr);
    assign procIndex = addrIndex(addr);

    // Tag match over the four ways
    assign hitMask = matchWays(procSet, reqTag);
    assign hit     = |hitMask;
    assign hitWay  = firstWay(hitMask);
    assign hitLine = procSet[hitWay];
    assign rdData  = hitLine.data;

    // Victim is the lowest free way, else the set's round-robin way
    always_comb
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            freeMask[w] = (procSet[w].state == Invalid);
        end
    end
    assign missWay = (|freeMask) ? firstWay(freeMask) : rrPtr[procIndex];
    assign tgtLine = procSet[tgtWay];

    // Read hit, or write hit in E or M, finishes without waiting
    assign done      = (state == Idle) && hit && (prRd || (hitLine.state != Shared));
    assign cpuStall  = req && !done;
    assign comBusReq = (state != Idle) || (req && !done);

    // Read fill is Shared when another cache holds the line
    always_comb
    begin
        if (prWr)
            fillState = Modified;
        else if (sharedIn)
            fillState = Shared;
        else
            fillState = Exclusive;
    end

    always_comb
    begin
        stateNext    = state;
        busOut       = '0;
        procWr       = '0;
        procWr.index = procIndex;
        procWr.way   = tgtWay;
        case (state)
            Idle:
            begin
                if (req && !done)
                begin
                    // Shared write needs ownership first
                    if (hit)
                        stateNext = Upgrade;
                    else if (procSet[missWay].state == Modified)
                        stateNext = WriteBack;
                    else
                        stateNext = Fill;
                end
                else if (done && prWr)
                begin
                    procWr.en   = 1'b1;
                    procWr.way  = hitWay;
                    procWr.line = '{tag: reqTag, state: Modified, data: wrData};
                end
            end
            WriteBack:
            begin
                if (comBusGnt)
                begin
                    busOut.memWr = 1'b1;
                    busOut.addr  = lineAddr(tgtLine.tag, procIndex);
                    busOut.data  = tgtLine.data;
                    // Memory now holds the victim, drop our copy
                    if (memWriteDone)
                    begin
                        stateNext          = Fill;
                        procWr.en          = 1'b1;
                        procWr.line        = tgtLine;
                        procWr.line.state  = Invalid;
                    end
                end
            end
            Fill:
            begin
                if (comBusGnt)
                begin
                    busOut.busRd  = prRd;
                    busOut.busRdX = prWr;
                    busOut.addr   = lineAddr(reqTag, procIndex);
                    // Install now, the write data goes in on the re-lookup
                    if (dataInBus)
                    begin
                        stateNext   = Idle;
                        procWr.en   = 1'b1;
                        procWr.line = '{tag: reqTag, state: fillState, data: fillData};
                    end
                end
            end
            Upgrade:
            begin
                if (comBusGnt)
                begin
                    busOut.invalidate = 1'b1;
                    busOut.addr       = lineAddr(reqTag, procIndex);
                    // Sole owner now, re-lookup writes it Modified
                    if (allInvalidationDone)
                    begin
                        stateNext         = Idle;
                        procWr.en         = 1'b1;
                        procWr.line       = tgtLine;
                        procWr.line.state = Exclusive;
                    end
                end
            end
            default:
                stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= Idle;
            for (int s = 0; s < SETS; s++)
            begin
                rrPtr[s] <= '0;
            end
        end
        else
        begin
            state <= stateNext;
            // Pointer moves only when it actually picked the victim
            if ((state == Idle) && req && !hit && !(|freeMask))
            begin
                rrPtr[procIndex] <= rrPtr[procIndex] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == Idle)
        begin
            tgtWay <= hit ? hitWay : missWay;
        end
    end

    aRdWrExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(prRd && prWr));

    aBusIdleNoGrant: assert property (@(posedge clk) disable iff (!rstN)
        !comBusGnt |-> (busOut == '0));

endmodule

`default_nettype wire

// ==== cacheSnoop/cacheSnoopCtl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheSnoopCtl (
    input  logic                clk,
    input  logic                rstN,
    input  cachePkg::snoopInT   snoopIn,
    output cachePkg::indexT     snoopIndex,
    input  cachePkg::setT       snoopSet,
    output cachePkg::lineWrT    snoopWr,
    output cachePkg::snoopRespT snoopResp
);
    import cachePkg::*;

    tagT       snoopTag;
    wayMaskT   hitMask;
    logic      hit;
    wayT       hitWay;
    lineT      hitLine;
    snoopRespT respNext;

    assign snoopIndex = addrIndex(snoopIn.addr);
    assign snoopTag   = addrTag(snoopIn.addr);

    // Own tag match, independent of the processor side
    assign hitMask = matchWays(snoopSet, snoopTag);
    assign hit     = |hitMask;
    assign hitWay  = firstWay(hitMask);
    assign hitLine = snoopSet[hitWay];

    always_comb
    begin
        respNext      = '0;
        snoopWr       = '0;
        snoopWr.index = snoopIndex;
        snoopWr.way   = hitWay;
        snoopWr.line  = hitLine;
        if (hit)
        begin
            if (snoopIn.busRd)
            begin
                // We supply the line, memory stays out
                respNext.shared    = 1'b1;
                respNext.dataInBus = 1'b1;
                respNext.memAbort  = 1'b1;
                respNext.data      = hitLine.data;
                if ((hitLine.state == Exclusive) || (hitLine.state == Modified))
                begin
                    snoopWr.en         = 1'b1;
                    snoopWr.line.state = Shared;
                end
            end
            else if (snoopIn.busRdX)
            begin
                // Only a dirty copy is newer than memory
                if (hitLine.state == Modified)
                begin
                    respNext.dataInBus = 1'b1;
                    respNext.memAbort  = 1'b1;
                    respNext.data      = hitLine.data;
                end
                snoopWr.en         = 1'b1;
                snoopWr.line.state = Invalid;
            end
            else if (snoopIn.invalidate)
            begin
                respNext.invalidationDone = 1'b1;
                snoopWr.en                = 1'b1;
                snoopWr.line.state        = Invalid;
            end
        end
    end

    // Answer appears the cycle after the strobe, zero otherwise
    always_ff @(posedge clk)
    begin
        if (!rstN)
            snoopResp <= '0;
        else
            snoopResp <= respNext;
    end

    aOneSnoopStrobe: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({snoopIn.busRd, snoopIn.busRdX, snoopIn.invalidate}));

endmodule

`default_nettype wire

// ==== common/cachePkg.sv ====
`default_nettype none

package cachePkg;

    // Address split is tag | index | byte offset
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int WAYS     = 4;
    localparam int SETS     = 16;
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 2;
    localparam int TAG_W    = 26;
    localparam int WAY_W    = 2;

    typedef logic [ADDR_W-1:0]  addrT;
    typedef logic [DATA_W-1:0]  dataT;
    typedef logic [TAG_W-1:0]   tagT;
    typedef logic [INDEX_W-1:0] indexT;
    typedef logic [WAY_W-1:0]   wayT;
    // One bit per way of a set
    typedef logic [WAYS-1:0]    wayMaskT;

    // MESI line states
    typedef enum logic [1:0] {
        Invalid   = 2'b00,
        Shared    = 2'b01,
        Exclusive = 2'b10,
        Modified  = 2'b11
    } mesiT;

    // One way's entry
    typedef struct packed {
        tagT  tag;
        mesiT state;
        dataT data;
    } lineT;

    // Whole set, way 0 in the low bits
    typedef lineT [WAYS-1:0] setT;

    // Write request into the line store
    typedef struct packed {
        logic  en;
        indexT index;
        wayT   way;
        lineT  line;
    } lineWrT;

    // Processor side drive onto the common bus
    typedef struct packed {
        logic busRd;
        logic busRdX;
        logic invalidate;
        logic memWr;
        addrT addr;
        dataT data;
    } busOutT;

    // Request of another cache as seen on the bus
    typedef struct packed {
        logic busRd;
        logic busRdX;
        logic invalidate;
        addrT addr;
    } snoopInT;

    // Answer of this cache to a snooped request
    typedef struct packed {
        logic shared;
        logic dataInBus;
        logic memAbort;
        logic invalidationDone;
        dataT data;
    } snoopRespT;

    // Processor side FSM
    typedef enum logic [1:0] {
        Idle,
        WriteBack,
        Fill,
        Upgrade
    } procStateT;

    function automatic indexT addrIndex(input addrT addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tagT addrTag(input addrT addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    // Line base address, offset bits zero
    function automatic addrT lineAddr(input tagT tag, input indexT index);
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

    // Ways holding a valid copy of the given tag
    function automatic wayMaskT matchWays(input setT set, input tagT tag);
        wayMaskT mask;
        for (int w = 0; w < WAYS; w++)
        begin
            mask[w] = (set[w].state != Invalid) && (set[w].tag == tag);
        end
        return mask;
    endfunction

    // Lowest way whose bit is set, way 0 when none
    function automatic wayT firstWay(input wayMaskT mask);
        wayT way;
        way = '0;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (mask[w])
            begin
                way = wayT'(w);
            end
        end
        return way;
    endfunction

endpackage

`default_nettype wire

// ==== dv/busMemModel.sv ====
`timescale 1ns/100ps
`default_nettype none

module busMemModel (
    input  logic             clk,
    input  logic             rstN,
    input  logic             comBusReq,
    input  cachePkg::busOutT busOut,
    output logic             comBusGnt,
    output logic             dataInBus,
    output logic             memWriteDone,
    output logic             allInvalidationDone,
    output cachePkg::dataT   fillData
);
    import cachePkg::*;

    localparam logic [31:0] LFSR_SEED   = 32'h177e_fa65;
    localparam dataT        MEM_PATTERN = 32'h5a5a_0000;

    // Lines written back so far, the rest of memory follows the pattern
    dataT        mem [addrT];
    logic [31:0] lfsr      = LFSR_SEED;
    // Cycles left before the next grant or response
    logic [1:0]  gntDelay  = 2'd1;
    logic [1:0]  respDelay = 2'd1;
    // Response registers, low from time zero
    logic        gntQ      = 1'b0;
    logic        fillQ     = 1'b0;
    logic        wbDoneQ   = 1'b0;
    logic        invDoneQ  = 1'b0;
    dataT        dataQ     = '0;
    // A done pulse is out, the cache consumes it on this edge
    logic        pulse;
    logic        cmd;

    assign comBusGnt           = gntQ;
    assign dataInBus           = fillQ;
    assign memWriteDone        = wbDoneQ;
    assign allInvalidationDone = invDoneQ;
    assign fillData            = dataQ;

    assign pulse = fillQ || wbDoneQ || invDoneQ;
    assign cmd   = busOut.busRd || busOut.busRdX || busOut.invalidate || busOut.memWr;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Latency of 0 to 3 cycles, one LFSR step per bit
    task automatic drawDelay(output logic [1:0] d);
        lfsr = lfsrStep(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsrStep(lfsr);
        d[1] = lfsr[0];
    endtask

    function automatic dataT memRead(input addrT a);
        if (mem.exists(a))
            return mem[a];
        else
            return a ^ MEM_PATTERN;
    endfunction

    always @(posedge clk)
    begin
        if (!rstN)
        begin
            gntQ      <= 1'b0;
            fillQ     <= 1'b0;
            wbDoneQ   <= 1'b0;
            invDoneQ  <= 1'b0;
            dataQ     <= '0;
            gntDelay  = 2'd1;
            respDelay = 2'd1;
        end
        else
        begin
            fillQ    <= 1'b0;
            wbDoneQ  <= 1'b0;
            invDoneQ <= 1'b0;
            if (!comBusReq)
                gntQ <= 1'b0;
            else if (!gntQ)
            begin
                // Arbitration latency
                if (gntDelay == 2'd0)
                begin
                    gntQ <= 1'b1;
                    drawDelay(gntDelay);
                end
                else
                    gntDelay = gntDelay - 2'd1;
            end
            else if (cmd && !pulse)
            begin
                if (respDelay != 2'd0)
                    respDelay = respDelay - 2'd1;
                else
                begin
                    drawDelay(respDelay);
                    if (busOut.memWr)
                    begin
                        mem[busOut.addr] = busOut.data;
                        wbDoneQ <= 1'b1;
                    end
                    else if (busOut.invalidate)
                        invDoneQ <= 1'b1;
                    else
                    begin
                        // busRd and busRdX both get the line
                        fillQ <= 1'b1;
                        dataQ <= memRead(busOut.addr);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/cacheStimulus.txt ====
// kind_flags_sharedIn_address_writeData_expected, one operation per line
// kind 1 read, 2 write, 3 snoop read, 4 snoop read-for-ownership, 5 snoop invalidate
// flags of reads and writes are bus commands 1 busRd, 2 busRdX, 4 invalidate, 8 memWr
// flags of snoops are responses 8 shared, 4 dataInBus, 2 memAbort, 1 invalidationDone
// Read miss, then a hit with no stall
1_1_0_00001000_00000000_5a5a1000
1_0_0_00001000_00000000_5a5a1000
// Write miss takes ownership
2_2_0_00002004_cafe0001_00000000
1_0_0_00002004_00000000_cafe0001
// Line filled Shared, the write invalidates first
1_1_1_00003008_00000000_5a5a3008
2_4_0_00003008_11112222_00000000
1_0_0_00003008_00000000_11112222
// Snoop read of a Modified line, then the write upgrades again
3_e_0_00003008_00000000_11112222
2_4_0_00003008_33334444_00000000
1_0_0_00003008_00000000_33334444
// Snoop invalidate, then the read misses
5_1_0_00001000_00000000_00000000
1_1_0_00001000_00000000_5a5a1000
// Snoop miss stays silent
3_0_0_00009000_00000000_00000000
// Read-for-ownership takes the dirty line away
4_6_0_00002004_00000000_cafe0001
1_1_0_00002004_00000000_5a5a2004
// Five tags in set 5, free ways first
2_2_0_00010014_a1a1a1a1_00000000
1_1_0_00020014_00000000_5a580014
1_1_0_00030014_00000000_5a590014
1_1_0_00040014_00000000_5a5e0014
// Way 0 is dirty and goes back to memory
1_9_0_00050014_00000000_5a5f0014
1_1_0_00010014_00000000_a1a1a1a1
// Round robin moves on to ways 2 and 3
1_0_0_00030014_00000000_5a590014
1_1_0_00020014_00000000_5a580014
1_0_0_00040014_00000000_5a5e0014
1_1_0_00030014_00000000_5a590014

// ==== dv/cacheTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheTb;
    import cachePkg::*;

    localparam int MAX_OPS     = 64;
    localparam int OP_W        = 108;
    // Cycle limits of the wait loops
    localparam int STALL_LIMIT = 200;
    localparam int RESET_LIMIT = 20;

    // Operation kinds in the stimulus file
    localparam logic [3:0] OP_END       = 4'h0;
    localparam logic [3:0] OP_RD        = 4'h1;
    localparam logic [3:0] OP_WR        = 4'h2;
    localparam logic [3:0] OP_SNOOP_RD  = 4'h3;
    localparam logic [3:0] OP_SNOOP_RDX = 4'h4;
    localparam logic [3:0] OP_SNOOP_INV = 4'h5;

    // One stimulus record
    typedef struct packed {
        logic [3:0] kind;
        // Bus commands {memWr, invalidate, busRdX, busRd}, or snoop response flags
        logic [3:0] flags;
        logic [3:0] sharer;
        addrT       addr;
        dataT       data;
        dataT       expData;
    } opT;

    logic      clk;
    logic      rstN;
    logic      prRd;
    logic      prWr;
    addrT      addr;
    dataT      wrData;
    dataT      rdData;
    logic      cpuStall;
    logic      comBusReq;
    logic      comBusGnt;
    busOutT    busOut;
    logic      dataInBus;
    logic      sharedIn;
    logic      memWriteDone;
    logic      allInvalidationDone;
    dataT      fillData;
    snoopInT   snoopIn;
    snoopRespT snoopResp;

    logic [OP_W-1:0] stim [MAX_OPS];
    // Latest processor write per line address
    dataT      written [addrT];
    opT        op;
    int        opIdx;
    int        checks;
    int        errors;
    int        failures;
    logic      stuck;

    clockGen uClock (
        .clk  (clk),
        .rstN (rstN)
    );

    busMemModel uMem (
        .clk                 (clk),
        .rstN                (rstN),
        .comBusReq           (comBusReq),
        .busOut              (busOut),
        .comBusGnt           (comBusGnt),
        .dataInBus           (dataInBus),
        .memWriteDone        (memWriteDone),
        .allInvalidationDone (allInvalidationDone),
        .fillData            (fillData)
    );

    cacheTop dut (
        .clk                 (clk),
        .rstN                (rstN),
        .prRd                (prRd),
        .prWr                (prWr),
        .addr                (addr),
        .wrData              (wrData),
        .rdData              (rdData),
        .cpuStall            (cpuStall),
        .comBusReq           (comBusReq),
        .comBusGnt           (comBusGnt),
        .busOut              (busOut),
        .dataInBus           (dataInBus),
        .sharedIn            (sharedIn),
        .memWriteDone        (memWriteDone),
        .allInvalidationDone (allInvalidationDone),
        .fillData            (fillData),
        .snoopIn             (snoopIn),
        .snoopResp           (snoopResp)
    );

    task automatic logError(input string msg);
        errors++;
        $display("ERR %0d ns: %s", $time, msg);
    endtask

    task automatic waitForReset(output logic timedOut);
        int waited;
        waited = 0;
        while ((rstN !== 1'b1) && (waited < RESET_LIMIT))
        begin
            @(posedge clk);
            waited++;
        end
        timedOut = (rstN !== 1'b1);
        if (timedOut)
        begin
            $display("Reset was never released");
            failures++;
        end
    endtask

    // Command seen on the bus this cycle, with address and write-back data checks
    task automatic checkBus(input addrT reqAddr, output logic [3:0] cmd);
        cmd = {busOut.memWr, busOut.invalidate, busOut.busRdX, busOut.busRd};
        if ((busOut.busRd || busOut.busRdX || busOut.invalidate) && (busOut.addr != reqAddr))
            logError($sformatf("bus address %h, expected %h", busOut.addr, reqAddr));
        // A victim goes back with the data last written to it
        if (busOut.memWr)
        begin
            if (!written.exists(busOut.addr))
                logError($sformatf("write-back of unwritten line %h", busOut.addr));
            else if (busOut.data != written[busOut.addr])
                logError($sformatf("write-back of %h carries %h, expected %h",
                    busOut.addr, busOut.data, written[busOut.addr]));
        end
    endtask

    task automatic processorAccess(input opT acc, output logic timedOut);
        int         waited;
        logic [3:0] cmd;
        logic [3:0] seen;
        waited   = 0;
        seen     = '0;
        timedOut = 1'b0;
        @(posedge clk);
        prRd     <= (acc.kind == OP_RD);
        prWr     <= (acc.kind == OP_WR);
        addr     <= acc.addr;
        wrData   <= acc.data;
        sharedIn <= acc.sharer[0];
        @(negedge clk);
        while (cpuStall && (waited < STALL_LIMIT))
        begin
            checkBus(acc.addr, cmd);
            seen = seen | cmd;
            // Bus stays requested for the whole miss or upgrade
            if (!comBusReq)
                logError($sformatf("comBusReq low while %h is stalled", acc.addr));
            waited++;
            @(negedge clk);
        end
        if (cpuStall)
        begin
            $display("Access to %h still stalled after %0d cycles", acc.addr, waited);
            failures++;
            timedOut = 1'b1;
        end
        else
        begin
            checks++;
            if (seen != acc.flags)
                logError($sformatf("bus commands %h for %h, expected %h",
                    seen, acc.addr, acc.flags));
            // No bus traffic means a hit, and a hit never waits
            if ((acc.flags == 4'h0) && (waited != 0))
                logError($sformatf("hit on %h stalled %0d cycles", acc.addr, waited));
            // Request drops once the FSM is back in Idle
            if (comBusReq)
                logError($sformatf("comBusReq still high after %h completed", acc.addr));
            if ((acc.kind == OP_RD) && (rdData != acc.expData))
                logError($sformatf("read of %h returned %h, expected %h",
                    acc.addr, rdData, acc.expData));
            if (acc.kind == OP_WR)
                written[acc.addr] = acc.data;
        end
        @(posedge clk);
        prRd     <= 1'b0;
        prWr     <= 1'b0;
        sharedIn <= 1'b0;
    endtask

    task automatic snoopRequest(input opT acc);
        snoopInT    strobe;
        logic [3:0] flags;
        strobe            = '0;
        strobe.busRd      = (acc.kind == OP_SNOOP_RD);
        strobe.busRdX     = (acc.kind == OP_SNOOP_RDX);
        strobe.invalidate = (acc.kind == OP_SNOOP_INV);
        strobe.addr       = acc.addr;
        @(posedge clk);
        snoopIn <= strobe;
        @(posedge clk);
        snoopIn <= '0;
        // Registered answer to the strobe just taken
        @(negedge clk);
        flags = {snoopResp.shared, snoopResp.dataInBus, snoopResp.memAbort,
                 snoopResp.invalidationDone};
        checks++;
        if (flags != acc.flags)
            logError($sformatf("snoop flags %h for %h, expected %h", flags, acc.addr, acc.flags));
        if (snoopResp.data != acc.expData)
            logError($sformatf("snoop data %h for %h, expected %h",
                snoopResp.data, acc.addr, acc.expData));
        @(negedge clk);
        if (snoopResp != '0)
            logError($sformatf("snoop response for %h held past one cycle", acc.addr));
    endtask

    initial
    begin
        prRd     <= 1'b0;
        prWr     <= 1'b0;
        addr     <= '0;
        wrData   <= '0;
        sharedIn <= 1'b0;
        snoopIn  <= '0;
        checks   = 0;
        errors   = 0;
        failures = 0;
        stuck    = 1'b0;
        for (int i = 0; i < MAX_OPS; i++)
            stim[i] = '0;
        $readmemh("dv/cacheStimulus.txt", stim);
        waitForReset(stuck);
        // Quiet bus and no stall right after reset
        if (!stuck)
        begin
            @(negedge clk);
            checks++;
            if (comBusReq || cpuStall || (busOut != '0) || (snoopResp != '0))
                logError("outputs not idle after reset");
        end
        opIdx = 0;
        op    = stim[0];
        while (!stuck && (op.kind != OP_END))
        begin
            if ((op.kind == OP_RD) || (op.kind == OP_WR))
                processorAccess(op, stuck);
            else if (op.kind <= OP_SNOOP_INV)
                snoopRequest(op);
            else
            begin
                $display("Unknown operation kind %h in stimulus entry %0d", op.kind, opIdx);
                failures++;
            end
            opIdx++;
            if (opIdx < MAX_OPS)
                op = stim[opIdx];
            else
                op = '0;
        end
        if ((opIdx == 0) && !stuck)
        begin
            $display("No operations found in the stimulus file");
            failures++;
        end
        $display("Operations: %0d  checks: %0d  errors: %0d  other failures: %0d",
            opIdx, checks, errors, failures);
        if ((errors == 0) && (failures == 0))
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);
    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held through the first 4 rising edges, released on the 4th
    initial
    begin
        rstN <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/cachePkg.sv
cacheProc/cacheProcCtl.sv
cacheSnoop/cacheSnoopCtl.sv
verilog/cacheLineStore.sv
verilog/cacheTop.sv
dv/clockGen.sv
dv/busMemModel.sv
dv/cacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build cacheTb with Verilator, run it, and grade the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cacheTb -f filelist.f -o cacheSim \
    && ./obj_dir/cacheSim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error"
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "RESULT: PASS" && exit 0 \
    || { echo "RESULT: FAIL"; exit 1; }

// ==== verilog/cacheLineStore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheLineStore (
    input  logic             clk,
    input  logic             rstN,
    input  cachePkg::indexT  procIndex,
    input  cachePkg::indexT  snoopIndex,
    output cachePkg::setT    procSet,
    output cachePkg::setT    snoopSet,
    input  cachePkg::lineWrT procWr,
    input  cachePkg::lineWrT snoopWr
);
    import cachePkg::*;

    // Tag, state and data of every line, one set per entry
    setT  sets [SETS];
    // Both sides aim at the same way of the same set
    logic collide;
    // Processor write that survives the merge
    logic procWrEn;

    // Two independent read ports
    assign procSet  = sets[procIndex];
    assign snoopSet = sets[snoopIndex];

    assign collide = procWr.en && snoopWr.en &&
                     (procWr.index == snoopWr.index) &&
                     (procWr.way == snoopWr.way);

    // Snoop side wins a shared entry
    assign procWrEn = procWr.en && !collide;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            // Every way of every set goes Invalid together
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < WAYS; w++)
                begin
                    sets[s][w].state <= Invalid;
                end
            end
        end
        else
        begin
            if (procWrEn)
            begin
                sets[procWr.index][procWr.way] <= procWr.line;
            end
            if (snoopWr.en)
            begin
                sets[snoopWr.index][snoopWr.way] <= snoopWr.line;
            end
        end
    end

    // Sides may share a set, but never the same line in one cycle
    aNoWriteCollision: assert property (@(posedge clk) disable iff (!rstN)
        !collide);

endmodule

`default_nettype wire

// ==== verilog/cacheTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheTop (
    input  logic                clk,
    input  logic                rstN,
    input  logic                prRd,
    input  logic                prWr,
    input  cachePkg::addrT      addr,
    input  cachePkg::dataT      wrData,
    output cachePkg::dataT      rdData,
    output logic                cpuStall,
    output logic                comBusReq,
    input  logic                comBusGnt,
    output cachePkg::busOutT    busOut,
    input  logic                dataInBus,
    input  logic                sharedIn,
    input  logic                memWriteDone,
    input  logic                allInvalidationDone,
    input  cachePkg::dataT      fillData,
    input  cachePkg::snoopInT   snoopIn,
    output cachePkg::snoopRespT snoopResp
);
    import cachePkg::*;

    // Lookup index and set of each side
    indexT  procIndex;
    indexT  snoopIndex;
    setT    procSet;
    setT    snoopSet;
    // Write requests into the shared arrays
    lineWrT procWr;
    lineWrT snoopWr;

    cacheProcCtl uProc (
        .clk                 (clk),
        .rstN                (rstN),
        .prRd                (prRd),
        .prWr                (prWr),
        .addr                (addr),
        .wrData              (wrData),
        .rdData              (rdData),
        .cpuStall            (cpuStall),
        .comBusReq           (comBusReq),
        .comBusGnt           (comBusGnt),
        .busOut              (busOut),
        .dataInBus           (dataInBus),
        .sharedIn            (sharedIn),
        .memWriteDone        (memWriteDone),
        .allInvalidationDone (allInvalidationDone),
        .fillData            (fillData),
        .procIndex           (procIndex),
        .procSet             (procSet),
        .procWr              (procWr)
    );

    cacheSnoopCtl uSnoop (
        .clk        (clk),
        .rstN       (rstN),
        .snoopIn    (snoopIn),
        .snoopIndex (snoopIndex),
        .snoopSet   (snoopSet),
        .snoopWr    (snoopWr),
        .snoopResp  (snoopResp)
    );

    cacheLineStore uStore (
        .clk        (clk),
        .rstN       (rstN),
        .procIndex  (procIndex),
        .snoopIndex (snoopIndex),
        .procSet    (procSet),
        .snoopSet   (snoopSet),
        .procWr     (procWr),
        .snoopWr    (snoopWr)
    );

    // A stalled processor access owns its line until it completes
    // Snooping that same line meanwhile would race the two sides
    aSnoopOnBusyLine: assert property (@(posedge clk) disable iff (!rstN)
        ((snoopIn.busRd || snoopIn.busRdX || snoopIn.invalidate) && cpuStall)
        |-> !((addrTag(snoopIn.addr) == addrTag(addr)) &&
              (addrIndex(snoopIn.addr) == addrIndex(addr))));

endmodule

`default_nettype wire
